// ==== hw/dp_pkg.sv ====
`default_nettype none

package dp_pkg;

    //////////////////////////////
    // widths
    localparam int data_width         = 32;
    localparam int reg_addr_width     = 4;
    localparam int shamt_width        = 5;
    localparam int shift_amount_width = 8;
    localparam int imm_width          = 8;

    //////////////////////////////
    // instruction field positions (lsb of each field)
    localparam int cond_lsb      = 28;
    localparam int op_lsb        = 26;
    localparam int i_bit         = 25;
    localparam int cmd_lsb       = 21;
    localparam int rn_lsb        = 16;
    localparam int rd_lsb        = 12;
    localparam int rs_lsb        = 8;
    localparam int shamt_lsb     = 7;
    localparam int sh_lsb        = 5;
    localparam int reg_shift_bit = 4;
    localparam int rm_lsb        = 0;
    localparam int imm8_lsb      = 0;

    // data-processing cmd codes in ARM encoding
    typedef enum logic [3:0] {
        cmd_and = 4'b0000,
        cmd_eor = 4'b0001,
        cmd_sub = 4'b0010,
        cmd_add = 4'b0100,
        cmd_orr = 4'b1100,
        cmd_mov = 4'b1101
    } alu_cmd_t;

    typedef enum logic [1:0] {
        sh_lsl = 2'b00,
        sh_lsr = 2'b01,
        sh_asr = 2'b10,
        sh_ror = 2'b11
    } shift_type_t;

    // decode -> execute
    typedef struct packed {
        logic                          valid;
        alu_cmd_t                      cmd;
        logic [reg_addr_width-1:0]     rd;
        logic [data_width-1:0]         operand_a;
        logic [data_width-1:0]         operand_b;
        shift_type_t                   shift_type;
        logic [shift_amount_width-1:0] shift_amount;
    } decoded_op_t;

    // execute -> write-back
    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] rd;
        logic [data_width-1:0]     value;
    } result_t;

endpackage

`default_nettype wire

// ==== hw/reg_read_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface reg_read_if;
    import dp_pkg::*;

    // Rn, Rm, Rs read ports
    logic [reg_addr_width-1:0] rn_addr;
    logic [reg_addr_width-1:0] rm_addr;
    logic [reg_addr_width-1:0] rs_addr;
    logic [data_width-1:0]     rn_data;
    logic [data_width-1:0]     rm_data;
    logic [data_width-1:0]     rs_data;

    modport decoder (
        output rn_addr, rm_addr, rs_addr,
        input  rn_data, rm_data, rs_data
    );

    modport reg_file (
        input  rn_addr, rm_addr, rs_addr,
        output rn_data, rm_data, rs_data
    );

endinterface

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic            clk,
    input  logic            reset,
    reg_read_if.reg_file    rd_port,
    input  dp_pkg::result_t wb
);
    import dp_pkg::*;

    localparam int num_regs = 1 << reg_addr_width;

    logic [data_width-1:0] regs [num_regs];

    //////////////////////////////
    // write port
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.value;
        end
    end

    //////////////////////////////
    // read ports
    // r15 is a plain register with no pc substitution
    assign rd_port.rn_data = regs[rd_port.rn_addr];
    assign rd_port.rm_data = regs[rd_port.rm_addr];
    assign rd_port.rs_data = regs[rd_port.rs_addr];

    // write-back payload comes two stages down from decode
    a_wb_rd_known: assert property (
        @(posedge clk) disable iff (reset)
        wb.valid |-> !$isunknown(wb.rd)
    ) else $error("reg_file: write with unknown destination %h", wb.rd);

endmodule

`default_nettype wire

// ==== hw/instr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
    input  logic                          instr_valid,
    input  logic [dp_pkg::data_width-1:0] instr,
    reg_read_if.decoder                   rd_port,
    input  dp_pkg::result_t               ex_bypass,
    input  dp_pkg::result_t               wb_bypass,
    output dp_pkg::decoded_op_t           op
);
    import dp_pkg::*;

    logic [1:0]            op_field;
    logic [3:0]            cmd_field;
    logic                  imm_sel;
    logic                  reg_shift;
    logic                  cmd_known;
    logic [data_width-1:0] rn_value;
    logic [data_width-1:0] rm_value;
    logic [data_width-1:0] rs_value;

    // newest producer wins so execute comes before write-back and the register file
    function automatic logic [data_width-1:0] bypass(
        input logic [reg_addr_width-1:0] addr,
        input logic [data_width-1:0]     file_value,
        input result_t                   ex,
        input result_t                   wb
    );
        if (ex.valid && ex.rd == addr) begin
            return ex.value;
        end else if (wb.valid && wb.rd == addr) begin
            return wb.value;
        end
        return file_value;
    endfunction

    //////////////////////////////
    // field extract
    assign op_field  = instr[op_lsb +: 2];
    assign cmd_field = instr[cmd_lsb +: 4];
    assign imm_sel   = instr[i_bit];
    assign reg_shift = instr[reg_shift_bit];

    assign rd_port.rn_addr = instr[rn_lsb +: reg_addr_width];
    assign rd_port.rm_addr = instr[rm_lsb +: reg_addr_width];
    assign rd_port.rs_addr = instr[rs_lsb +: reg_addr_width];

    always_comb begin
        case (cmd_field)
            cmd_and, cmd_eor, cmd_sub, cmd_add, cmd_orr, cmd_mov: cmd_known = 1'b1;
            default: cmd_known = 1'b0;
        endcase
    end

    //////////////////////////////
    // operands
    always_comb begin
        rn_value = bypass(rd_port.rn_addr, rd_port.rn_data, ex_bypass, wb_bypass);
        rm_value = bypass(rd_port.rm_addr, rd_port.rm_data, ex_bypass, wb_bypass);
        rs_value = bypass(rd_port.rs_addr, rd_port.rs_data, ex_bypass, wb_bypass);
    end

    always_comb begin
        // anything other than op 00 with a known cmd is dropped here
        op.valid     = instr_valid && op_field == 2'b00 && cmd_known;
        op.cmd       = alu_cmd_t'(cmd_field);
        op.rd        = instr[rd_lsb +: reg_addr_width];
        op.operand_a = rn_value;
        if (imm_sel) begin
            // rotate field ignored and imm8 zero extended
            op.operand_b    = {{(data_width-imm_width){1'b0}}, instr[imm8_lsb +: imm_width]};
            op.shift_type   = sh_lsl;
            op.shift_amount = '0;
        end else begin
            op.operand_b  = rm_value;
            op.shift_type = shift_type_t'(instr[sh_lsb +: 2]);
            if (reg_shift) begin
                op.shift_amount = rs_value[shift_amount_width-1:0];
            end else begin
                op.shift_amount = {{(shift_amount_width-shamt_width){1'b0}},
                                   instr[shamt_lsb +: shamt_width]};
            end
        end
    end

    always_comb begin
        if (instr_valid) begin
            a_instr_known: assert final (!$isunknown(instr))
                else $error("instr_decode: instruction has unknown bits %h", instr);
        end
    end

endmodule

`default_nettype wire

// ==== hw/stage_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

// one pipeline register whose payload type is chosen per instance
module stage_reg #(
    parameter type payload_t = dp_pkg::result_t
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload has valid low
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/shift_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module shift_alu (
    input  dp_pkg::decoded_op_t op,
    output dp_pkg::result_t     result
);
    import dp_pkg::*;

    logic [shamt_width-1:0]  rot;
    logic [shamt_width-1:0]  asr_amt;
    logic                    big;
    logic [2*data_width-1:0] ror_wide;
    logic [data_width-1:0]   shifted;
    logic [data_width-1:0]   alu_value;

    //////////////////////////////
    // barrel shifter
    always_comb begin
        rot      = op.shift_amount[shamt_width-1:0];
        // any amount of 32 or more
        big      = |op.shift_amount[shift_amount_width-1:shamt_width];
        // asr past 31 is the same as asr by 31
        asr_amt  = big ? '1 : rot;
        ror_wide = {op.operand_b, op.operand_b} >> rot;

        if (op.shift_amount == '0) begin
            shifted = op.operand_b;
        end else begin
            case (op.shift_type)
                sh_lsl:  shifted = big ? '0 : op.operand_b << rot;
                sh_lsr:  shifted = big ? '0 : op.operand_b >> rot;
                sh_asr:  shifted = $signed(op.operand_b) >>> asr_amt;
                default: shifted = ror_wide[data_width-1:0];
            endcase
        end
    end

    //////////////////////////////
    // alu
    always_comb begin
        case (op.cmd)
            cmd_and: alu_value = op.operand_a & shifted;
            cmd_eor: alu_value = op.operand_a ^ shifted;
            cmd_sub: alu_value = op.operand_a - shifted;
            cmd_add: alu_value = op.operand_a + shifted;
            cmd_orr: alu_value = op.operand_a | shifted;
            cmd_mov: alu_value = shifted;
            default: alu_value = '0;
        endcase
    end

    assign result.valid = op.valid;
    assign result.rd    = op.rd;
    assign result.value = alu_value;

    // decode only lets known cmds through with valid set
    always_comb begin
        if (op.valid) begin
            a_cmd_known: assert final (
                op.cmd inside {cmd_and, cmd_eor, cmd_sub, cmd_add, cmd_orr, cmd_mov}
            ) else $error("shift_alu: valid op with unknown cmd %h", op.cmd);
        end
    end

endmodule

`default_nettype wire

// ==== hw/dp_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module dp_core (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              instr_valid,
    input  logic [dp_pkg::data_width-1:0]     instr,
    output logic                              result_valid,
    output logic [dp_pkg::reg_addr_width-1:0] result_reg,
    output logic [dp_pkg::data_width-1:0]     result_data
);
    import dp_pkg::*;

    decoded_op_t dec_op;
    decoded_op_t ex_op;
    result_t     ex_result;
    result_t     wb_result;

    reg_read_if rd_bus ();

    //////////////////////////////
    // decode
    instr_decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_port     (rd_bus.decoder),
        .ex_bypass   (ex_result),
        .wb_bypass   (wb_result),
        .op          (dec_op)
    );

    stage_reg #(.payload_t(decoded_op_t)) u_op_stage (
        .clk   (clk),
        .reset (reset),
        .d     (dec_op),
        .q     (ex_op)
    );

    //////////////////////////////
    // execute
    shift_alu u_shift_alu (
        .op     (ex_op),
        .result (ex_result)
    );

    stage_reg #(.payload_t(result_t)) u_wb_stage (
        .clk   (clk),
        .reset (reset),
        .d     (ex_result),
        .q     (wb_result)
    );

    //////////////////////////////
    // write-back
    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rd_port (rd_bus.reg_file),
        .wb      (wb_result)
    );

    assign result_valid = wb_result.valid;
    assign result_reg   = wb_result.rd;
    assign result_data  = wb_result.value;

endmodule

`default_nettype wire

// ==== sim/dp_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dp_core_tb;

    localparam int wait_limit = 20;

    // one expected write-back and the cycle count when it should show up
    typedef struct packed {
        logic [31:0] due;
        logic [3:0]  rd;
        logic [31:0] value;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        result_valid;
    logic [3:0]  result_reg;
    logic [31:0] result_data;

    expect_t     expect_q [$];
    expect_t     head;
    int          cycle = 0;
    int          checks;
    int          errors;
    int          tests;

    dp_core i_dut (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result_reg   (result_reg),
        .result_data  (result_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic send_instr(input logic [31:0] word, input logic has_result,
                              input logic [3:0] rd, input logic [31:0] value);
        expect_t item;
        @(posedge clk);
        #1;
        instr_valid = 1'b1;
        instr       = word;
        if (has_result) begin
            item.due   = cycle + 2;
            item.rd    = rd;
            item.value = value;
            expect_q.push_back(item);
        end
    endtask

    task automatic drain_results(input int test_num);
        int waited;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
        waited      = 0;
        while (expect_q.size() != 0 && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            errors++;
            $display("test %0d: expected result for r%0d never arrived", test_num,
                     expect_q[0].rd);
            expect_q.delete();
        end
        // a stray result from the last instruction would land within two edges
        repeat (2) @(posedge clk);
        tests++;
        $display("test %0d done", test_num);
    endtask

    //////////////////////////////
    // result monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("at %0t a result for r%0d appeared where none was expected",
                         $time, result_reg);
            end else begin
                head = expect_q.pop_front();
                compare_value(cycle, head.due, "result cycle");
                compare_value(result_reg, head.rd, "result_reg");
                compare_value(result_data, head.value, "result_data");
            end
        end
    end

    //////////////////////////////
    // stimulus from trace
    initial begin
        int          fd;
        int          got;
        int          cur_test;
        int          tn;
        int          flag;
        logic [31:0] word;
        logic [31:0] exp_rd;
        logic [31:0] exp_value;
        string       line;

        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        // idle pipeline so the monitor flags any result here
        repeat (4) @(posedge clk);

        fd = $fopen("sim/dp_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open trace file sim/dp_trace.txt");
        end else begin
            cur_test = -1;
            while (!$feof(fd)) begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 0 && $sscanf(line, "%d %h %d %h %h", tn, word, flag,
                                       exp_rd, exp_value) == 5) begin
                    if (tn != cur_test && cur_test >= 0) begin
                        drain_results(cur_test);
                    end
                    cur_test = tn;
                    send_instr(word, flag != 0, exp_rd[3:0], exp_value);
                end
            end
            if (cur_test >= 0) begin
                drain_results(cur_test);
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/dp_pkg.sv
hw/reg_read_if.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/stage_reg.sv
hw/shift_alu.sv
hw/dp_core.sv
sim/dp_core_tb.sv

// ==== sim/dp_trace.txt ====
# columns: test  instr(hex)  expect(0/1)  rd(hex)  value(hex)
# expect 0 means the instruction must leave no result behind
1 E3A01012 1 1 00000012
1 E3A024FF 1 2 000000FF
1 E3A0F001 1 F 00000001
2 E2814034 1 4 00000046
2 E2415020 1 5 FFFFFFF2
2 E0026004 1 6 00000046
2 E0227005 1 7 FFFFFF0D
2 E38180C0 1 8 000000D2
2 E0859007 1 9 FFFFFEFF
3 E1A0B201 1 B 00000120
3 E1A0C225 1 C 0FFFFFFF
3 E1A0D245 1 D FFFFFFFF
3 E1A0E462 1 E FF000000
3 E1A0B047 1 B FFFFFF0D
4 E3A0201F 1 2 0000001F
4 E3A04020 1 4 00000020
4 E3A06028 1 6 00000028
4 E3A0A024 1 A 00000024
4 E1A07315 1 7 FFFFFFF2
4 E1A09235 1 9 00000001
4 E1A0B415 1 B 00000000
4 E1A0C655 1 C FFFFFFFF
4 E1A0DA78 1 D 2000000D
4 E1A0E638 1 E 00000000
5 E3A01005 1 1 00000005
5 E2812003 1 2 00000008
5 E0813002 1 3 0000000D
5 E0434001 1 4 00000008
5 E1845082 1 5 00000018
5 E3A07002 1 7 00000002
5 E1A08735 1 8 00000006
5 E08FF00F 1 F 00000002
5 E28F9001 1 9 00000003
6 E3A01055 1 1 00000055
6 E5911000 0 0 00000000
6 E2611000 0 0 00000000
6 EA000000 0 0 00000000
6 E1A02001 1 2 00000055
